//--- logic/turfio_defs.svh
`ifndef TURFIO_DEFS_SVH
`define TURFIO_DEFS_SVH

// INITCLK cycles per half period of LMKCLK
`define TURFIO_LMK_DIV 4

// INITCLK cycles per half period of TCK
`define TURFIO_JTAG_DIV 4

// APB address width in bits
`define TURFIO_APB_AW 8

// Register byte offsets
`define TURFIO_REG_CTRL   8'h00
`define TURFIO_REG_LMK    8'h04
`define TURFIO_REG_STATUS 8'h08
`define TURFIO_REG_TMS    8'h0C
`define TURFIO_REG_TDI    8'h10
`define TURFIO_REG_JCMD   8'h14
`define TURFIO_REG_TDO    8'h18

`endif

//--- logic/turfio_pkg.sv
`include "turfio_defs.svh"

package turfio_pkg;

    // APB bus
    typedef logic [`TURFIO_APB_AW-1:0] apb_addr_t;
    typedef logic [31:0]               apb_data_t;

    // LMK word goes out MSB first
    typedef logic [31:0] lmk_word_t;

    // Bit 0 of a JTAG vector leaves first
    typedef logic [31:0] jtag_vec_t;
    // Shift length minus one gives 1 to 32 bits per shift
    typedef logic [4:0]  jtag_len_t;

    typedef enum logic [1:0] {
        LMK_IDLE, LMK_SETUP, LMK_CLK_HI, LMK_LATCH
    } lmk_state_e;

    typedef enum logic [1:0] {
        JTAG_IDLE, JTAG_TCK_LO, JTAG_TCK_HI
    } jtag_state_e;

endpackage

//--- logic/turfio_apb_regs.sv
`include "turfio_defs.svh"

module turfio_apb_regs
    import turfio_pkg::*;
(
    input  logic      INITCLK,
    input  logic      rst_n,
    input  apb_addr_t paddr,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_data_t pwdata,
    output apb_data_t prdata,
    output logic      pready,
    output logic      pslverr,
    output logic      jtag_en,
    output logic      drive_jtag,
    output logic      en_3v3,
    output logic      lmk_oe,
    output logic      lmk_start,
    output lmk_word_t lmk_word,
    input  logic      lmk_busy,
    output logic      jtag_start,
    output jtag_vec_t jtag_tms,
    output jtag_vec_t jtag_tdi,
    output jtag_len_t jtag_len,
    input  logic      jtag_busy,
    input  jtag_vec_t jtag_tdo
);

    logic      access;
    logic      addr_hit;
    logic      read_only;
    logic      refused;
    logic      xfer_err;
    logic      wr_ok;
    apb_data_t rd_mux;

    //////////////////////////////////////////////////////////////////////
    // Decode and error
    //////////////////////////////////////////////////////////////////////

    assign access = psel & penable;
    assign pready = 1'b1;

    always_comb begin
        addr_hit  = 1'b1;
        read_only = 1'b0;
        refused   = 1'b0;
        rd_mux    = '0;
        case (paddr)
            `TURFIO_REG_CTRL: rd_mux = {28'd0, lmk_oe, en_3v3, drive_jtag, jtag_en};
            `TURFIO_REG_LMK: begin
                rd_mux  = lmk_word;
                // Pending start counts as busy
                refused = lmk_busy | lmk_start;
            end
            `TURFIO_REG_STATUS: begin
                rd_mux    = {30'd0, jtag_busy, lmk_busy};
                read_only = 1'b1;
            end
            `TURFIO_REG_TMS: rd_mux = jtag_tms;
            `TURFIO_REG_TDI: rd_mux = jtag_tdi;
            `TURFIO_REG_JCMD: begin
                rd_mux  = {27'd0, jtag_len};
                refused = jtag_busy | jtag_start;
            end
            `TURFIO_REG_TDO: begin
                rd_mux    = jtag_tdo;
                read_only = 1'b1;
            end
            default: addr_hit = 1'b0;
        endcase
    end

    assign xfer_err = !addr_hit | (pwrite & (read_only | refused));
    assign pslverr  = access & xfer_err;
    assign prdata   = (access && !pwrite && !xfer_err) ? rd_mux : '0;
    assign wr_ok    = access & pwrite & !xfer_err;

    //////////////////////////////////////////////////////////////////////
    // Board enables and start pulses
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge INITCLK) begin
        if (!rst_n) begin
            jtag_en    <= 1'b0;
            drive_jtag <= 1'b0;
            en_3v3     <= 1'b1;
            lmk_oe     <= 1'b1;
        end else if (wr_ok && paddr == `TURFIO_REG_CTRL) begin
            jtag_en    <= pwdata[0];
            drive_jtag <= pwdata[1];
            en_3v3     <= pwdata[2];
            lmk_oe     <= pwdata[3];
        end
    end

    // One cycle after the accepted access phase
    always_ff @(posedge INITCLK) begin
        if (!rst_n) begin
            lmk_start  <= 1'b0;
            jtag_start <= 1'b0;
        end else begin
            lmk_start  <= wr_ok && (paddr == `TURFIO_REG_LMK);
            jtag_start <= wr_ok && (paddr == `TURFIO_REG_JCMD);
        end
    end

    // Data registers for the engines
    always_ff @(posedge INITCLK) begin
        if (wr_ok) begin
            case (paddr)
                `TURFIO_REG_LMK:  lmk_word <= pwdata;
                `TURFIO_REG_TMS:  jtag_tms <= pwdata;
                `TURFIO_REG_TDI:  jtag_tdi <= pwdata;
                `TURFIO_REG_JCMD: jtag_len <= pwdata[4:0];
                default: ;
            endcase
        end
    end

    // Host keeps psel through the access phase
    a_penable_psel: assert property (@(posedge INITCLK) disable iff (!rst_n)
        penable |-> psel);

    // Engines must already be idle when their start arrives
    a_lmk_start_idle: assert property (@(posedge INITCLK) disable iff (!rst_n)
        lmk_start |-> !lmk_busy);
    a_jtag_start_idle: assert property (@(posedge INITCLK) disable iff (!rst_n)
        jtag_start |-> !jtag_busy);

endmodule

//--- logic/lmk_shift_reg.sv
`include "turfio_defs.svh"

module lmk_shift_reg
    import turfio_pkg::*;
#(
    parameter int DIV = `TURFIO_LMK_DIV
) (
    input  logic      INITCLK,
    input  logic      rst_n,
    input  logic      start,
    input  lmk_word_t word,
    output logic      busy,
    output logic      lmkdata,
    output logic      lmkclk,
    output logic      lmkle
);

    // Counter also reaches DIV for the tail cycle after LMKLE
    localparam int              DIVW     = $clog2(DIV + 1);
    localparam logic [DIVW-1:0] DIV_LAST = DIVW'(DIV - 1);
    localparam logic [DIVW-1:0] DIV_END  = DIVW'(DIV);

    lmk_state_e      state;
    logic [DIVW-1:0] div_cnt;
    logic            phase_end;
    logic [4:0]      bit_cnt;
    lmk_word_t       shreg;

    assign busy = (state != LMK_IDLE);

    // Latch phase holds one more cycle with LMKLE already low
    assign phase_end = (state == LMK_LATCH) ? (div_cnt == DIV_END) : (div_cnt == DIV_LAST);

    always_ff @(posedge INITCLK) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (state == LMK_IDLE || phase_end) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + DIVW'(1);
        end
    end

    always_ff @(posedge INITCLK) begin
        if (!rst_n) begin
            state   <= LMK_IDLE;
            lmkdata <= 1'b0;
            lmkclk  <= 1'b0;
            lmkle   <= 1'b0;
        end else begin
            case (state)
                LMK_IDLE: if (start) begin
                    state   <= LMK_SETUP;
                    lmkdata <= word[31];
                end
                LMK_SETUP: if (phase_end) begin
                    state  <= LMK_CLK_HI;
                    lmkclk <= 1'b1;
                end
                LMK_CLK_HI: if (phase_end) begin
                    lmkclk <= 1'b0;
                    if (bit_cnt == 5'd31) begin
                        state <= LMK_LATCH;
                        lmkle <= 1'b1;
                    end else begin
                        state   <= LMK_SETUP;
                        lmkdata <= shreg[30];
                    end
                end
                LMK_LATCH: begin
                    if (div_cnt == DIV_LAST) begin
                        lmkle <= 1'b0;
                    end
                    if (phase_end) begin
                        state   <= LMK_IDLE;
                        lmkdata <= 1'b0;
                    end
                end
                default: state <= LMK_IDLE;
            endcase
        end
    end

    // Shift register and bit count
    always_ff @(posedge INITCLK) begin
        if (state == LMK_IDLE && start) begin
            shreg   <= word;
            bit_cnt <= '0;
        end else if (state == LMK_CLK_HI && phase_end) begin
            shreg   <= shreg << 1;
            bit_cnt <= bit_cnt + 5'd1;
        end
    end

    a_le_clk_low: assert property (@(posedge INITCLK) disable iff (!rst_n)
        lmkle |-> !lmkclk);

    a_no_start_busy: assert property (@(posedge INITCLK) disable iff (!rst_n)
        start |-> !busy);

endmodule

//--- logic/jtag_shifter.sv
`include "turfio_defs.svh"

module jtag_shifter
    import turfio_pkg::*;
#(
    parameter int DIV = `TURFIO_JTAG_DIV
) (
    input  logic      INITCLK,
    input  logic      rst_n,
    input  logic      start,
    input  jtag_vec_t tms_vec,
    input  jtag_vec_t tdi_vec,
    input  jtag_len_t len,
    output logic      busy,
    output logic      tck,
    output logic      tms,
    output logic      tdi,
    input  logic      tdo,
    output jtag_vec_t tdo_vec
);

    localparam int              DIVW     = (DIV > 1) ? $clog2(DIV) : 1;
    localparam logic [DIVW-1:0] DIV_LAST = DIVW'(DIV - 1);

    jtag_state_e     state;
    logic [DIVW-1:0] div_cnt;
    logic            div_done;
    jtag_vec_t       tms_sr;
    jtag_vec_t       tdi_sr;
    jtag_len_t       len_q;
    jtag_len_t       bit_idx;

    assign busy     = (state != JTAG_IDLE);
    assign div_done = (div_cnt == DIV_LAST);

    // TCK half period divider
    always_ff @(posedge INITCLK) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (state == JTAG_IDLE || div_done) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + DIVW'(1);
        end
    end

    always_ff @(posedge INITCLK) begin
        if (!rst_n) begin
            state   <= JTAG_IDLE;
            tck     <= 1'b0;
            tms     <= 1'b0;
            tdi     <= 1'b0;
            tdo_vec <= '0;
        end else begin
            case (state)
                JTAG_IDLE: if (start) begin
                    state   <= JTAG_TCK_LO;
                    tms     <= tms_vec[0];
                    tdi     <= tdi_vec[0];
                    // Unshifted bits must read back as 0
                    tdo_vec <= '0;
                end
                JTAG_TCK_LO: if (div_done) begin
                    state            <= JTAG_TCK_HI;
                    tck              <= 1'b1;
                    // Capture TDO as TCK goes high
                    tdo_vec[bit_idx] <= tdo;
                end
                JTAG_TCK_HI: if (div_done) begin
                    tck <= 1'b0;
                    if (bit_idx == len_q) begin
                        state <= JTAG_IDLE;
                        tms   <= 1'b0;
                        tdi   <= 1'b0;
                    end else begin
                        state <= JTAG_TCK_LO;
                        tms   <= tms_sr[1];
                        tdi   <= tdi_sr[1];
                    end
                end
                default: state <= JTAG_IDLE;
            endcase
        end
    end

    // Vectors shift right so the next bit sits at index 1
    always_ff @(posedge INITCLK) begin
        if (state == JTAG_IDLE && start) begin
            tms_sr  <= tms_vec;
            tdi_sr  <= tdi_vec;
            len_q   <= len;
            bit_idx <= '0;
        end else if (state == JTAG_TCK_HI && div_done) begin
            tms_sr  <= tms_sr >> 1;
            tdi_sr  <= tdi_sr >> 1;
            bit_idx <= bit_idx + 5'd1;
        end
    end

    a_tck_idle_low: assert property (@(posedge INITCLK) disable iff (!rst_n)
        (state == JTAG_IDLE) |-> !tck);

endmodule

//--- logic/turfio_ctrl_top.sv
`include "turfio_defs.svh"

module turfio_ctrl_top
    import turfio_pkg::*;
(
    input  logic      INITCLK,
    input  logic      rst_n,
    input  apb_addr_t paddr,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_data_t pwdata,
    output apb_data_t prdata,
    output logic      pready,
    output logic      pslverr,
    output logic      jtag_en,
    output logic      en_3v3,
    output logic      lmk_oe,
    output logic      jtag_oe,
    output logic      tck,
    output logic      tms,
    output logic      tdi,
    input  logic      tdo,
    output logic      lmkdata,
    output logic      lmkclk,
    output logic      lmkle
);

    logic      lmk_start;
    lmk_word_t lmk_word;
    logic      lmk_busy;
    logic      jtag_start;
    jtag_vec_t jtag_tms;
    jtag_vec_t jtag_tdi;
    jtag_len_t jtag_len;
    logic      jtag_busy;
    jtag_vec_t jtag_tdo;

    //////////////////////////////////////////////////////////////////////
    // Host registers
    //////////////////////////////////////////////////////////////////////

    // drive_jtag goes straight out as the shared JTAG pin enable
    turfio_apb_regs u_regs (
        .INITCLK   (INITCLK),
        .rst_n     (rst_n),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .jtag_en   (jtag_en),
        .drive_jtag(jtag_oe),
        .en_3v3    (en_3v3),
        .lmk_oe    (lmk_oe),
        .lmk_start (lmk_start),
        .lmk_word  (lmk_word),
        .lmk_busy  (lmk_busy),
        .jtag_start(jtag_start),
        .jtag_tms  (jtag_tms),
        .jtag_tdi  (jtag_tdi),
        .jtag_len  (jtag_len),
        .jtag_busy (jtag_busy),
        .jtag_tdo  (jtag_tdo)
    );

    //////////////////////////////////////////////////////////////////////
    // Serial engines
    //////////////////////////////////////////////////////////////////////

    lmk_shift_reg #(.DIV(`TURFIO_LMK_DIV)) u_lmk (
        .INITCLK(INITCLK),
        .rst_n  (rst_n),
        .start  (lmk_start),
        .word   (lmk_word),
        .busy   (lmk_busy),
        .lmkdata(lmkdata),
        .lmkclk (lmkclk),
        .lmkle  (lmkle)
    );

    jtag_shifter #(.DIV(`TURFIO_JTAG_DIV)) u_jtag (
        .INITCLK(INITCLK),
        .rst_n  (rst_n),
        .start  (jtag_start),
        .tms_vec(jtag_tms),
        .tdi_vec(jtag_tdi),
        .len    (jtag_len),
        .busy   (jtag_busy),
        .tck    (tck),
        .tms    (tms),
        .tdi    (tdi),
        .tdo    (tdo),
        .tdo_vec(jtag_tdo)
    );

endmodule

//--- dv/tb_clkgen.sv
module tb_clkgen #(
    parameter int HALF_PERIOD  = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic INITCLK,
    output logic rst_n
);

    initial begin
        INITCLK = 1'b0;
        forever #HALF_PERIOD INITCLK = ~INITCLK;
    end

    // Release on a falling edge away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge INITCLK);
        @(negedge INITCLK);
        rst_n = 1'b1;
    end

endmodule

//--- dv/tb_turfio.sv
`include "turfio_defs.svh"

module tb_turfio
    import turfio_pkg::*;
;

    localparam logic [31:0] SEED       = 32'h98740233;
    localparam int          APB_LIMIT  = 16;
    localparam int          BUSY_LIMIT = 400;
    localparam int          RST_LIMIT  = 20;

    logic      INITCLK;
    logic      rst_n;
    apb_addr_t paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
    logic      jtag_en;
    logic      en_3v3;
    logic      lmk_oe;
    logic      jtag_oe;
    logic      tck;
    logic      tms;
    logic      tdi;
    logic      tdo;
    logic      lmkdata;
    logic      lmkclk;
    logic      lmkle;

    logic [31:0] lfsr_q;
    int          err_count     = 0;
    int          timeout_count = 0;
    event        run_abort;

    // Register model
    logic [3:0] ctrl_m;
    lmk_word_t  lmk_m;
    jtag_vec_t  tms_m;
    jtag_vec_t  tdi_m;
    jtag_len_t  len_m;
    jtag_vec_t  tdo_m;

    // Pin monitor state
    logic      lmkclk_q      = 1'b0;
    logic      lmkle_q       = 1'b0;
    logic      tck_q         = 1'b0;
    lmk_word_t lmk_sr;
    lmk_word_t lmk_cap_word;
    int        lmk_run_bits  = 0;
    int        lmk_cap_bits  = 0;
    int        lmk_clk_total = 0;
    int        lmk_le_count  = 0;
    int        tck_rises     = 0;

    tb_clkgen u_clkgen (
        .INITCLK(INITCLK),
        .rst_n  (rst_n)
    );

    turfio_ctrl_top i_dut (
        .INITCLK(INITCLK),
        .rst_n  (rst_n),
        .paddr  (paddr),
        .psel   (psel),
        .penable(penable),
        .pwrite (pwrite),
        .pwdata (pwdata),
        .prdata (prdata),
        .pready (pready),
        .pslverr(pslverr),
        .jtag_en(jtag_en),
        .en_3v3 (en_3v3),
        .lmk_oe (lmk_oe),
        .jtag_oe(jtag_oe),
        .tck    (tck),
        .tms    (tms),
        .tdi    (tdi),
        .tdo    (tdo),
        .lmkdata(lmkdata),
        .lmkclk (lmkclk),
        .lmkle  (lmkle)
    );

    // Downstream chain model
    assign tdo = tms ^ tdi;

    //////////////////////////////////////////////////////////////////////
    // Pin monitors
    //////////////////////////////////////////////////////////////////////

    // Edges found from the previous clock's values
    always @(posedge INITCLK) begin
        if (lmkclk && !lmkclk_q) begin
            lmk_sr = {lmk_sr[30:0], lmkdata};
            lmk_run_bits++;
            lmk_clk_total++;
        end
        if (lmkle && !lmkle_q) begin
            lmk_cap_word = lmk_sr;
            lmk_cap_bits = lmk_run_bits;
            lmk_run_bits = 0;
            lmk_le_count++;
        end
        if (tck && !tck_q) begin
            tck_rises++;
        end
        lmkclk_q = lmkclk;
        lmkle_q  = lmkle;
        tck_q    = tck;
    end

    //////////////////////////////////////////////////////////////////////
    // Random numbers and expected values
    //////////////////////////////////////////////////////////////////////

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // Captured bits 0 to len with zeros above
    function automatic jtag_vec_t tdo_expect(input jtag_vec_t t, input jtag_vec_t d,
                                             input jtag_len_t l);
        jtag_vec_t mask;
        mask = '0;
        for (int i = 0; i <= int'(l); i++) begin
            mask[i] = 1'b1;
        end
        return (t ^ d) & mask;
    endfunction

    function automatic apb_data_t pin_state();
        return {22'd0, lmkle, lmkclk, lmkdata, tdi, tms, tck,
                lmk_oe, en_3v3, jtag_oe, jtag_en};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Compare tasks and end of run
    //////////////////////////////////////////////////////////////////////

    task automatic check_data(input string what, input apb_data_t got, input apb_data_t exp);
        if (got !== exp) begin
            err_count++;
            $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_lmk(input string what, input lmk_word_t got, input lmk_word_t exp);
        if (got !== exp) begin
            err_count++;
            $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_tdo(input string what, input jtag_vec_t got, input jtag_vec_t exp);
        if (got !== exp) begin
            err_count++;
            $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_err(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            err_count++;
            $display("[ERROR] %0t: %s pslverr %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("Run complete with %0d value errors and %0d timeouts",
                 err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    // Hands the end of the run to the abort process and stalls the caller
    task automatic timed_out(input string what);
        timeout_count++;
        $display("Gave up waiting at time %0t because %s", $time, what);
        -> run_abort;
        forever @(negedge INITCLK);
    endtask

    initial begin
        @(run_abort);
        finish_run();
    end

    //////////////////////////////////////////////////////////////////////
    // APB driver
    //////////////////////////////////////////////////////////////////////

    task automatic apb_access(input apb_addr_t addr, input logic wr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err);
        int n;
        @(negedge INITCLK);
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge INITCLK);
        penable = 1'b1;
        #10;
        n = 0;
        while (!pready && n < APB_LIMIT) begin
            @(negedge INITCLK);
            #10;
            n++;
        end
        if (!pready) begin
            timed_out("the APB slave never raised pready");
        end else begin
            rdata = prdata;
            err   = pslverr;
            @(negedge INITCLK);
            psel    = 1'b0;
            penable = 1'b0;
            pwrite  = 1'b0;
        end
    endtask

    task automatic write_reg(input apb_addr_t addr, input apb_data_t data,
                             input logic exp_err, input string what);
        apb_data_t rd;
        logic      err;
        apb_access(addr, 1'b1, data, rd, err);
        check_err(what, err, exp_err);
    endtask

    task automatic read_reg(input apb_addr_t addr, output apb_data_t data,
                            input logic exp_err, input string what);
        logic err;
        apb_access(addr, 1'b0, '0, data, err);
        check_err(what, err, exp_err);
    endtask

    // Polls STATUS until the given busy bit clears
    task automatic wait_idle(input int bit_pos, input string what);
        apb_data_t st;
        logic      err;
        int        n;
        n  = 0;
        st = '1;
        while (st[bit_pos] && n < BUSY_LIMIT) begin
            apb_access(`TURFIO_REG_STATUS, 1'b0, '0, st, err);
            check_err({what, " status poll"}, err, 1'b0);
            n++;
        end
        if (st[bit_pos]) begin
            timed_out({what, " stayed busy"});
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Engine sequences
    //////////////////////////////////////////////////////////////////////

    task automatic run_lmk(input lmk_word_t w, input logic poke);
        int        le0;
        int        clk0;
        apb_data_t rd;
        le0  = lmk_le_count;
        clk0 = lmk_clk_total;
        write_reg(`TURFIO_REG_LMK, w, 1'b0, "LMK write");
        lmk_m = w;
        if (poke) begin
            write_reg(`TURFIO_REG_LMK, ~w, 1'b1, "LMK write while busy");
        end
        wait_idle(0, "LMK serializer");
        check_data("LMKLE pulses", apb_data_t'(lmk_le_count - le0), 32'd1);
        check_data("LMKCLK rises", apb_data_t'(lmk_clk_total - clk0), 32'd32);
        check_data("bits before LMKLE", apb_data_t'(lmk_cap_bits), 32'd32);
        check_lmk("LMK word on pins", lmk_cap_word, w);
        read_reg(`TURFIO_REG_STATUS, rd, 1'b0, "STATUS read");
        check_data("STATUS after LMK", rd, 32'd0);
        read_reg(`TURFIO_REG_LMK, rd, 1'b0, "LMK read");
        check_lmk("LMK readback", rd, w);
    endtask

    task automatic run_jtag(input jtag_len_t len, input jtag_vec_t t, input jtag_vec_t d,
                            input logic poke);
        int        rises0;
        apb_data_t hi;
        apb_data_t rd;
        write_reg(`TURFIO_REG_TMS, t, 1'b0, "TMS write");
        tms_m = t;
        write_reg(`TURFIO_REG_TDI, d, 1'b0, "TDI write");
        tdi_m  = d;
        rises0 = tck_rises;
        hi     = rand_bits(27);
        write_reg(`TURFIO_REG_JCMD, {hi[26:0], len}, 1'b0, "JCMD write");
        len_m = len;
        if (poke) begin
            write_reg(`TURFIO_REG_JCMD, {hi[26:0], ~len}, 1'b1, "JCMD write while busy");
        end
        wait_idle(1, "JTAG engine");
        check_data("TCK rises", apb_data_t'(tck_rises - rises0), apb_data_t'(int'(len) + 1));
        tdo_m = tdo_expect(t, d, len);
        read_reg(`TURFIO_REG_TDO, rd, 1'b0, "TDO read");
        check_tdo("TDO vector", rd, tdo_m);
        read_reg(`TURFIO_REG_JCMD, rd, 1'b0, "JCMD read");
        check_data("JCMD readback", rd, {27'd0, len});
    endtask

    task automatic check_regs();
        apb_data_t rd;
        read_reg(`TURFIO_REG_CTRL, rd, 1'b0, "CTRL read");
        check_data("CTRL", rd, {28'd0, ctrl_m});
        read_reg(`TURFIO_REG_LMK, rd, 1'b0, "LMK read");
        check_lmk("LMK", rd, lmk_m);
        read_reg(`TURFIO_REG_TMS, rd, 1'b0, "TMS read");
        check_data("TMS", rd, tms_m);
        read_reg(`TURFIO_REG_TDI, rd, 1'b0, "TDI read");
        check_data("TDI", rd, tdi_m);
        read_reg(`TURFIO_REG_JCMD, rd, 1'b0, "JCMD read");
        check_data("JCMD", rd, {27'd0, len_m});
        read_reg(`TURFIO_REG_TDO, rd, 1'b0, "TDO read");
        check_tdo("TDO", rd, tdo_m);
    endtask

    task automatic probe_unmapped(input apb_addr_t a);
        apb_data_t rd;
        read_reg(a, rd, 1'b1, "unmapped read");
        check_data("unmapped read data", rd, 32'd0);
        write_reg(a, rand_bits(32), 1'b1, "unmapped write");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        apb_data_t rd;
        apb_data_t w;
        apb_data_t r;
        int        n;
        lfsr_q  = SEED;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        ctrl_m  = 4'hC;

        n = 0;
        while (rst_n !== 1'b1 && n < RST_LIMIT) begin
            @(posedge INITCLK);
            n++;
        end
        if (rst_n !== 1'b1) begin
            timed_out("reset was never released");
        end

        // State right after reset
        read_reg(`TURFIO_REG_CTRL, rd, 1'b0, "CTRL read");
        check_data("CTRL after reset", rd, 32'h0000_000C);
        read_reg(`TURFIO_REG_STATUS, rd, 1'b0, "STATUS read");
        check_data("STATUS after reset", rd, 32'd0);
        check_data("pins after reset", pin_state(), 32'h0000_000C);

        // Board enables follow CTRL
        for (int i = 0; i < 8; i++) begin
            w = rand_bits(32);
            write_reg(`TURFIO_REG_CTRL, w, 1'b0, "CTRL write");
            ctrl_m = w[3:0];
            read_reg(`TURFIO_REG_CTRL, rd, 1'b0, "CTRL read");
            check_data("CTRL readback", rd, {28'd0, ctrl_m});
            check_data("board pins", pin_state(), {28'd0, ctrl_m});
        end
        for (int i = 0; i < 4; i++) begin
            tms_m = rand_bits(32);
            tdi_m = rand_bits(32);
            write_reg(`TURFIO_REG_TMS, tms_m, 1'b0, "TMS write");
            write_reg(`TURFIO_REG_TDI, tdi_m, 1'b0, "TDI write");
            read_reg(`TURFIO_REG_TMS, rd, 1'b0, "TMS read");
            check_data("TMS readback", rd, tms_m);
            read_reg(`TURFIO_REG_TDI, rd, 1'b0, "TDI read");
            check_data("TDI readback", rd, tdi_m);
        end

        for (int i = 0; i < 4; i++) begin
            run_lmk(rand_bits(32), 1'b0);
        end

        // Shortest and longest shifts first
        run_jtag(5'd0, rand_bits(32), rand_bits(32), 1'b0);
        run_jtag(5'd31, rand_bits(32), rand_bits(32), 1'b0);
        for (int i = 0; i < 5; i++) begin
            r = rand_bits(5);
            run_jtag(r[4:0], rand_bits(32), rand_bits(32), 1'b0);
        end

        // Starts refused while busy
        run_lmk(rand_bits(32), 1'b1);
        r = rand_bits(5);
        run_jtag(r[4:0], rand_bits(32), rand_bits(32), 1'b1);

        // Read-only registers
        write_reg(`TURFIO_REG_STATUS, rand_bits(32), 1'b1, "STATUS write");
        read_reg(`TURFIO_REG_STATUS, rd, 1'b0, "STATUS read");
        check_data("STATUS after refused write", rd, 32'd0);
        write_reg(`TURFIO_REG_TDO, rand_bits(32), 1'b1, "TDO write");
        check_regs();

        // Offsets 0x1C, 0x20 and up, and unaligned ones are all unmapped
        probe_unmapped(8'h1C);
        probe_unmapped(8'h02);
        for (int i = 0; i < 6; i++) begin
            r = rand_bits(8);
            probe_unmapped(r[7:0] | 8'h20);
        end
        check_regs();
        check_data("pins at end", pin_state(), {28'd0, ctrl_m});

        finish_run();
    end

endmodule

//--- flist.f
+incdir+logic
logic/turfio_pkg.sv
logic/turfio_apb_regs.sv
logic/lmk_shift_reg.sv
logic/jtag_shifter.sv
logic/turfio_ctrl_top.sv
dv/tb_clkgen.sv
dv/tb_turfio.sv

//--- Makefile
# Verilator build and run of the slow-control testbench

VERILATOR ?= verilator
TOP       ?= tb_turfio
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
